// File: list.f
+incdir+testbench
verilog/rv32Pkg.sv
verilog/pipeCtrlPkg.sv
verilog/instrDecoder.sv
verilog/controlPipe.sv
verilog/hazardUnit.sv
verilog/pipelineControl.sv
testbench/pipelineControlTb.sv

// File: Bender.yml
package:
  name: pipeline_control

sources:
  - files:
      - verilog/rv32Pkg.sv
      - verilog/pipeCtrlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/controlPipe.sv
      - verilog/hazardUnit.sv
      - verilog/pipelineControl.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/pipelineControlTb.sv

// File: testbench/pipelineVectors.svh
/*
 * Stimulus and expected values for the pipeline control testbench.
 * One row per cycle: instruction, fetch ready, mispredict, then the
 * expected immSrc, {stallF, stallD, flushD, flushE}, forwards and bundles.
 */
`ifndef PIPELINE_VECTORS_SVH
`define PIPELINE_VECTORS_SVH

// Instruction fields: funct7, rs2, rs1, funct3, rd, opcode
task automatic buildTable();
    logic [31:0] nopI;
    stageExpT    nopE;
    nopI = enc(7'h00, 5'd0, 5'd0, f3AddSub, 5'd0, opItypeAlu);
    nopE = bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, 5'd0);
    // Miss before the first fetch, PC keeps moving
    addRow(enc(7'h00, 5'd5, 5'd0, f3AddSub, a, opItypeAlu), 0, 0, immI, 4'b0101,
           fwdReg, fwdReg, bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, a));
    plain(enc(7'h00, 5'd5, 5'd0, f3AddSub, a, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, a));
    // R-type forms
    plain(enc(7'h00, 5'd0, 5'd0, f3AddSub, c, opRtype), immI,
          bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h20, 5'd0, 5'd0, f3AddSub, c, opRtype), immI,
          bun(aluSub, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd0, 5'd0, f3Slt, c, opRtype), immI,
          bun(aluSlt, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd0, 5'd0, f3Or, c, opRtype), immI,
          bun(aluOr, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd0, 5'd0, f3And, c, opRtype), immI,
          bun(aluAnd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    // I-type forms, imm bit 10 set must not subtract
    plain(enc(7'h00, 5'd1, 5'd0, f3Slt, c, opItypeAlu), immI,
          bun(aluSlt, 1, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd1, 5'd0, f3Or, c, opItypeAlu), immI,
          bun(aluOr, 1, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd1, 5'd0, f3And, c, opItypeAlu), immI,
          bun(aluAnd, 1, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h20, 5'd0, 5'd0, f3AddSub, c, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, c));
    // Memory, branch, jump, upper immediate
    plain(enc(7'h00, 5'd0, 5'd0, 3'b010, c, opLoad), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultMem, 1, c));
    plain(enc(7'h00, 5'd0, 5'd0, 3'b010, 5'd0, opStore), immS,
          bun(aluAdd, 1, 0, 0, 0, 1, resultAlu, 0, 5'd0));
    plain(enc(7'h00, 5'd0, 5'd0, f3Beq, 5'd0, opBranch), immB,
          bun(aluSub, 0, 1, 0, 0, 0, resultAlu, 0, 5'd0));
    plain(enc(7'h00, 5'd0, 5'd0, f3Bne, 5'd0, opBranch), immB,
          bun(aluSub, 0, 1, 0, 1, 0, resultAlu, 0, 5'd0));
    plain(enc(7'h00, 5'd0, 5'd0, 3'd0, c, opJal), immJ,
          bun(aluAdd, 0, 0, 1, 0, 0, resultPc4, 1, c));
    plain(enc(7'h00, 5'd0, 5'd0, 3'd0, c, opJalr), immI,
          bun(aluAdd, 0, 0, 1, 0, 0, resultPc4, 1, c));
    plain(enc(7'h12, 5'd3, 5'd0, 3'd0, c, opLui), immU,
          bun(aluAdd, 0, 0, 0, 0, 0, resultImm, 1, c));
    // Unsupported opcode is a bubble
    plain(enc(7'h7f, 5'd9, 5'd7, 3'd5, 5'd3, 7'h7f), immI, '0);
    // Distance 1 and 2 producers
    plain(enc(7'h00, 5'd1, 5'd0, f3AddSub, a, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, a));
    plain(enc(7'h00, 5'd2, 5'd0, f3AddSub, b, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, b));
    plain(enc(7'h00, a, b, f3AddSub, c, opRtype), immI,
          bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    addRow(nopI, 1, 0, immI, 4'b0000, fwdMem, fwdWb, nopE);
    // Both stages write the same register
    plain(enc(7'h00, 5'd3, 5'd0, f3AddSub, a, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, a));
    plain(enc(7'h00, 5'd4, 5'd0, f3AddSub, a, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, a));
    plain(enc(7'h00, a, a, f3AddSub, c, opRtype), immI,
          bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    addRow(nopI, 1, 0, immI, 4'b0000, fwdMem, fwdMem, nopE);
    // Writes to x0 never forward
    plain(enc(7'h00, 5'd7, 5'd0, f3AddSub, 5'd0, opItypeAlu), immI, nopE);
    plain(enc(7'h00, 5'd0, 5'd0, f3AddSub, c, opRtype), immI,
          bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(nopI, immI, nopE);
    // Load followed by a user, one bubble then the held add
    plain(enc(7'h00, 5'd0, 5'd0, 3'b010, a, opLoad), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultMem, 1, a));
    addRow(enc(7'h00, 5'd0, a, f3AddSub, c, opRtype), 1, 0, immI, 4'b1101,
           fwdReg, fwdReg, bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd0, a, f3AddSub, c, opRtype), immI,
          bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    addRow(nopI, 1, 0, immI, 4'b0000, fwdWb, fwdReg, nopE);
    // Mispredict kills decode and execute
    addRow(enc(7'h00, 5'd0, 5'd0, f3AddSub, c, opRtype), 1, 1, immI, 4'b0011,
           fwdReg, fwdReg, bun(aluAdd, 0, 0, 0, 0, 0, resultAlu, 1, c));
    plain(nopI, immI, nopE);
    // Miss after fetch started stalls fetch too
    addRow(enc(7'h00, 5'd1, 5'd0, f3AddSub, c, opItypeAlu), 0, 0, immI, 4'b1101,
           fwdReg, fwdReg, bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, c));
    addRow(enc(7'h00, 5'd1, 5'd0, f3AddSub, c, opItypeAlu), 0, 0, immI, 4'b1101,
           fwdReg, fwdReg, bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, c));
    plain(enc(7'h00, 5'd1, 5'd0, f3AddSub, c, opItypeAlu), immI,
          bun(aluAdd, 1, 0, 0, 0, 0, resultAlu, 1, c));
    plain(nopI, immI, nopE);
endtask

`endif

// File: testbench/pipelineControlTb.sv
/*
 * Testbench for the pipeline control top level.
 * Table-driven checks of decode, forwarding, load-use, mispredict and fetch miss.
 */
module pipelineControlTb
    import rv32Pkg::*;
    import pipeCtrlPkg::*;
();

    // Expected bundles entering execute
    typedef struct packed {
        exCtrlT  ex;
        memCtrlT mem;
        wbCtrlT  wb;
    } stageExpT;

    typedef struct packed {
        logic [31:0] instr;
        logic        ready;
        logic        misp;
        logic [2:0]  imm;
        // stallF, stallD, flushD, flushE
        logic [3:0]  hz;
        logic [1:0]  fwdA;
        logic [1:0]  fwdB;
        stageExpT    exp;
    } vecRowT;

    logic        clk;
    logic        reset;
    logic [31:0] instrD;
    logic        fetchReady;
    logic        mispredictE;
    logic [2:0]  immSrcD;
    exCtrlT      exCtrlE;
    memCtrlT     memCtrlM;
    wbCtrlT      wbCtrlW;
    logic [1:0]  forwardAE;
    logic [1:0]  forwardBE;
    logic        stallF;
    logic        stallD;
    logic        flushD;
    logic        flushE;

    vecRowT   vectors[$];
    // Index 0 execute, 1 memory, 2 writeback
    stageExpT pipeQ[$];
    integer   seed;
    regAddrT  a;
    regAddrT  b;
    regAddrT  c;
    int       cycles = 0;
    int       limit = 100;

    pipelineControl UUT (
        .clk           (clk),
        .reset         (reset),
        .instrD_i      (instrD),
        .fetchReady_i  (fetchReady),
        .mispredictE_i (mispredictE),
        .immSrcD_o     (immSrcD),
        .exCtrlE_o     (exCtrlE),
        .memCtrlM_o    (memCtrlM),
        .wbCtrlW_o     (wbCtrlW),
        .forwardAE_o   (forwardAE),
        .forwardBE_o   (forwardBE),
        .stallF_o      (stallF),
        .stallD_o      (stallD),
        .flushD_o      (flushD),
        .flushE_o      (flushE)
    );

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic stageExpT bun(input logic [2:0] aluC, input logic src,
                                     input logic br, input logic jmp, input logic bt,
                                     input logic mw, input logic [1:0] rs,
                                     input logic rw, input regAddrT rd);
        stageExpT e;
        e.ex.aluControl = aluC;
        e.ex.aluSrc     = src;
        e.ex.branch     = br;
        e.ex.jump       = jmp;
        e.ex.branchType = bt;
        e.mem.memWrite  = mw;
        e.mem.resultSrc = rs;
        e.wb.regWrite   = rw;
        e.wb.resultSrc  = rs;
        e.wb.rd         = rd;
        return e;
    endfunction

    function automatic void addRow(input logic [31:0] instr, input logic ready,
                                   input logic misp, input logic [2:0] imm,
                                   input logic [3:0] hz, input logic [1:0] fwdA,
                                   input logic [1:0] fwdB, input stageExpT exp);
        vecRowT r;
        r.instr = instr;
        r.ready = ready;
        r.misp  = misp;
        r.imm   = imm;
        r.hz    = hz;
        r.fwdA  = fwdA;
        r.fwdB  = fwdB;
        r.exp   = exp;
        vectors.push_back(r);
    endfunction

    // Ready, no mispredict, no hazard
    function automatic void plain(input logic [31:0] instr, input logic [2:0] imm,
                                  input stageExpT exp);
        addRow(instr, 1, 0, imm, 4'b0000, fwdReg, fwdReg, exp);
    endfunction

    `include "pipelineVectors.svh"

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic checkStages();
        checkVal("exCtrlE_o", exCtrlE, pipeQ[0].ex);
        checkVal("memCtrlM_o", memCtrlM, pipeQ[1].mem);
        checkVal("wbCtrlW_o", wbCtrlW, pipeQ[2].wb);
    endtask

    task automatic advanceStages(input stageExpT e);
        pipeQ.push_front(e);
        void'(pipeQ.pop_back());
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout, DUT run exceeded %0d cycles", limit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    initial begin
        reset       = 1'b1;
        instrD      = '0;
        fetchReady  = 1'b0;
        mispredictE = 1'b0;
        seed = 32'hc17;
        a = regAddrT'($random(seed));
        if (a == '0) begin
            a = 5'd1;
        end
        // Distinct nonzero neighbours
        b = regAddrT'((a % 31) + 1);
        c = regAddrT'((b % 31) + 1);
        buildTable();
        limit = vectors.size() + 16 + 20;
        pipeQ = '{'0, '0, '0};

        // Only reset keeps this self-dependent load out of execute
        instrD     = enc(7'h00, 5'd0, a, 3'b010, a, opLoad);
        fetchReady = 1'b1;

        repeat (16) begin
            @(posedge clk);
            #1;
            checkStages();
            checkVal("forwardAE_o", forwardAE, fwdReg);
            checkVal("forwardBE_o", forwardBE, fwdReg);
            checkVal("stallF_o", stallF, 1'b0);
        end
        reset      = 1'b0;
        fetchReady = 1'b0;

        foreach (vectors[i]) begin
            @(posedge clk);
            #1;
            checkStages();
            instrD      = vectors[i].instr;
            fetchReady  = vectors[i].ready;
            mispredictE = vectors[i].misp;
            #3;
            checkVal("immSrcD_o", immSrcD, vectors[i].imm);
            checkVal("stallF_o", stallF, vectors[i].hz[3]);
            checkVal("stallD_o", stallD, vectors[i].hz[2]);
            checkVal("flushD_o", flushD, vectors[i].hz[1]);
            checkVal("flushE_o", flushE, vectors[i].hz[0]);
            checkVal("forwardAE_o", forwardAE, vectors[i].fwdA);
            checkVal("forwardBE_o", forwardBE, vectors[i].fwdB);
            // A flush sends a bubble instead
            advanceStages(vectors[i].hz[0] ? stageExpT'('0) : vectors[i].exp);
        end

        // Drain the last rows out to writeback
        repeat (3) begin
            @(posedge clk);
            #1;
            checkStages();
            instrD = '0;
            advanceStages('0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verilog/pipelineControl.sv
/*
 * Pipeline control top level.
 * Connects the decoder, the control pipeline and the hazard unit
 * of the five-stage RV32I core.
 */
module pipelineControl
    import rv32Pkg::*;
    import pipeCtrlPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instrD_i,
    input  logic        fetchReady_i,
    input  logic        mispredictE_i,
    output logic [2:0]  immSrcD_o,
    output exCtrlT      exCtrlE_o,
    output memCtrlT     memCtrlM_o,
    output wbCtrlT      wbCtrlW_o,
    output logic [1:0]  forwardAE_o,
    output logic [1:0]  forwardBE_o,
    output logic        stallF_o,
    output logic        stallD_o,
    output logic        flushD_o,
    output logic        flushE_o
);

    // Decode stage bundle
    decodedT    decodedD;

    // Stage state fed back to the hazard unit
    stageAddrT  addrE;
    logic [1:0] resultSrcE;
    logic       regWriteM;
    regAddrT    rdM;

    instrDecoder u_instrDecoder (
        .instr_i   (instrD_i),
        .decoded_o (decodedD)
    );

    // Immediate select goes straight to the extender
    assign immSrcD_o = decodedD.immSrc;

    controlPipe u_controlPipe (
        .clk          (clk),
        .reset        (reset),
        .decoded_i    (decodedD),
        .flushE_i     (flushE_o),
        .exCtrlE_o    (exCtrlE_o),
        .addrE_o      (addrE),
        .resultSrcE_o (resultSrcE),
        .memCtrlM_o   (memCtrlM_o),
        .regWriteM_o  (regWriteM),
        .rdM_o        (rdM),
        .wbCtrlW_o    (wbCtrlW_o)
    );

    hazardUnit u_hazardUnit (
        .clk           (clk),
        .reset         (reset),
        .rs1D_i        (decodedD.rs1),
        .rs2D_i        (decodedD.rs2),
        .addrE_i       (addrE),
        .resultSrcE_i  (resultSrcE),
        .regWriteM_i   (regWriteM),
        .rdM_i         (rdM),
        .wbCtrlW_i     (wbCtrlW_o),
        .fetchReady_i  (fetchReady_i),
        .mispredictE_i (mispredictE_i),
        .forwardAE_o   (forwardAE_o),
        .forwardBE_o   (forwardBE_o),
        .stallF_o      (stallF_o),
        .stallD_o      (stallD_o),
        .flushD_o      (flushD_o),
        .flushE_o      (flushE_o)
    );

endmodule

// File: verilog/hazardUnit.sv
/*
 * Hazard unit.
 * ALU operand forwarding with memory-stage priority,
 * load-use and fetch-miss stalls, mispredict flushes.
 */
module hazardUnit
    import rv32Pkg::*;
    import pipeCtrlPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  regAddrT    rs1D_i,
    input  regAddrT    rs2D_i,
    input  stageAddrT  addrE_i,
    input  logic [1:0] resultSrcE_i,
    input  logic       regWriteM_i,
    input  regAddrT    rdM_i,
    input  wbCtrlT     wbCtrlW_i,
    input  logic       fetchReady_i,
    input  logic       mispredictE_i,
    output logic [1:0] forwardAE_o,
    output logic [1:0] forwardBE_o,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o
);

    logic loadUseStall;
    logic fetchMiss;
    // Set once the cache has delivered anything
    logic fetchStarted;

    // Forward select for one execute source register
    function automatic logic [1:0] fwdSelect(input regAddrT src, input logic wrM,
                                             input regAddrT rdM, input wbCtrlT wb);
        logic hitM;
        logic hitW;
        hitM = wrM && (rdM == src) && (src != '0);
        hitW = wb.regWrite && (wb.rd == src) && (src != '0);
        // Youngest producer wins
        if (hitM) begin
            return fwdMem;
        end else if (hitW) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign forwardAE_o = fwdSelect(addrE_i.rs1, regWriteM_i, rdM_i, wbCtrlW_i);
    assign forwardBE_o = fwdSelect(addrE_i.rs2, regWriteM_i, rdM_i, wbCtrlW_i);

    // Load in execute whose rd is read in decode
    assign loadUseStall = (resultSrcE_i == resultMem) && (addrE_i.rd != '0)
                       && ((addrE_i.rd == rs1D_i) || (addrE_i.rd == rs2D_i));

    assign fetchMiss = !fetchReady_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchStarted <= 1'b0;
        end else if (fetchReady_i) begin
            fetchStarted <= 1'b1;
        end
    end

    // Before the first fetch the PC must still advance
    assign stallF_o = loadUseStall || (fetchMiss && fetchStarted);
    assign stallD_o = loadUseStall || fetchMiss;
    assign flushD_o = mispredictE_i;
    // Decode holds, so execute gets a bubble and not a copy
    assign flushE_o = loadUseStall || mispredictE_i || fetchMiss;

endmodule

// File: verilog/controlPipe.sv
/*
 * Control pipeline registers.
 * Carries decoded control and register addresses through
 * execute, memory and writeback. Execute flushes to a bubble.
 */
module controlPipe
    import rv32Pkg::*;
    import pipeCtrlPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  decodedT    decoded_i,
    input  logic       flushE_i,
    output exCtrlT     exCtrlE_o,
    output stageAddrT  addrE_o,
    output logic [1:0] resultSrcE_o,
    output memCtrlT    memCtrlM_o,
    output logic       regWriteM_o,
    output regAddrT    rdM_o,
    output wbCtrlT     wbCtrlW_o
);

    // Execute stage state beyond the outputs
    memCtrlT memCtrlE;
    logic    regWriteE;

    // Execute register
    // Flush replaces the incoming instruction with a bubble
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            exCtrlE_o <= '0;
            memCtrlE  <= '0;
            regWriteE <= 1'b0;
            addrE_o   <= '0;
        end else begin
            exCtrlE_o   <= decoded_i.ex;
            memCtrlE    <= decoded_i.mem;
            regWriteE   <= decoded_i.regWrite;
            addrE_o.rs1 <= decoded_i.rs1;
            addrE_o.rs2 <= decoded_i.rs2;
            addrE_o.rd  <= decoded_i.rd;
        end
    end

    // Load-use check looks at this
    assign resultSrcE_o = memCtrlE.resultSrc;

    // Memory register, never stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            memCtrlM_o  <= '0;
            regWriteM_o <= 1'b0;
            rdM_o       <= '0;
        end else begin
            memCtrlM_o  <= memCtrlE;
            regWriteM_o <= regWriteE;
            rdM_o       <= addrE_o.rd;
        end
    end

    // Writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            wbCtrlW_o <= '0;
        end else begin
            wbCtrlW_o.regWrite  <= regWriteM_o;
            wbCtrlW_o.resultSrc <= memCtrlM_o.resultSrc;
            wbCtrlW_o.rd        <= rdM_o;
        end
    end

endmodule

// File: verilog/instrDecoder.sv
/*
 * Decode stage instruction decoder.
 * Main decoder by opcode, ALU decoder and branch type,
 * packed into one decoded bundle. Unsupported opcodes give zero.
 */
module instrDecoder
    import rv32Pkg::*;
    import pipeCtrlPkg::*;
(
    input  logic [31:0] instr_i,
    output decodedT     decoded_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    // Main decoder outputs
    logic       regWrite;
    logic [2:0] immSrc;
    logic       aluSrc;
    logic       memWrite;
    logic [1:0] resultSrc;
    logic       branch;
    logic [1:0] aluOp;
    logic       jump;

    // Which register fields the instruction really reads
    logic       useRs1;
    logic       useRs2;

    logic [2:0] aluControl;
    logic       branchType;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7b5 = instr_i[30];

    // Main decoder table
    // regWrite_immSrc_aluSrc_memWrite_resultSrc_branch_aluOp_jump
    always_comb begin
        useRs1 = 1'b1;
        useRs2 = 1'b0;
        case (opcode)
            opLoad:
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b1, immI, 1'b1, 1'b0, resultMem, 1'b0, aluOpAdd, 1'b0};
            opStore: begin
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b0, immS, 1'b1, 1'b1, resultAlu, 1'b0, aluOpAdd, 1'b0};
                useRs2 = 1'b1;
            end
            opRtype: begin
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b1, immI, 1'b0, 1'b0, resultAlu, 1'b0, aluOpFunct, 1'b0};
                useRs2 = 1'b1;
            end
            opBranch: begin
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b0, immB, 1'b0, 1'b0, resultAlu, 1'b1, aluOpSub, 1'b0};
                useRs2 = 1'b1;
            end
            opItypeAlu:
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b1, immI, 1'b1, 1'b0, resultAlu, 1'b0, aluOpFunct, 1'b0};
            opJal: begin
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b1, immJ, 1'b0, 1'b0, resultPc4, 1'b0, aluOpAdd, 1'b1};
                useRs1 = 1'b0;
            end
            opJalr:
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b1, immI, 1'b0, 1'b0, resultPc4, 1'b0, aluOpAdd, 1'b1};
            opLui: begin
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} =
                    {1'b1, immU, 1'b0, 1'b0, resultImm, 1'b0, aluOpAdd, 1'b0};
                useRs1 = 1'b0;
            end
            default: begin
                // Bubble
                {regWrite, immSrc, aluSrc, memWrite, resultSrc, branch, aluOp, jump} = '0;
                useRs1 = 1'b0;
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        case (aluOp)
            aluOpSub:   aluControl = aluSub;
            aluOpFunct: begin
                case (funct3)
                    // Subtract only for R-type with funct7[5] set
                    f3AddSub: aluControl = (funct7b5 && opcode[5]) ? aluSub : aluAdd;
                    f3Slt:    aluControl = aluSlt;
                    f3Or:     aluControl = aluOr;
                    f3And:    aluControl = aluAnd;
                    default:  aluControl = aluAdd;
                endcase
            end
            default:    aluControl = aluAdd;
        endcase
    end

    // bne inverts the zero test, beq and everything else leave it
    assign branchType = branch && (funct3 == f3Bne);

    always_comb begin
        decoded_o.ex.aluControl   = aluControl;
        decoded_o.ex.aluSrc       = aluSrc;
        decoded_o.ex.branch       = branch;
        decoded_o.ex.jump         = jump;
        decoded_o.ex.branchType   = branchType;
        decoded_o.mem.memWrite    = memWrite;
        decoded_o.mem.resultSrc   = resultSrc;
        decoded_o.regWrite        = regWrite;
        decoded_o.immSrc          = immSrc;
        // Unused fields hold immediate bits, zero them
        decoded_o.rs1 = useRs1 ? regAddrT'(instr_i[19:15]) : '0;
        decoded_o.rs2 = useRs2 ? regAddrT'(instr_i[24:20]) : '0;
        decoded_o.rd  = regWrite ? regAddrT'(instr_i[11:7]) : '0;
    end

endmodule

// File: verilog/pipeCtrlPkg.sv
/*
 * Pipeline control bundles.
 * Packed per-stage control structs, result select codes
 * and operand forwarding selects.
 */
package pipeCtrlPkg;

    import rv32Pkg::*;

    // Writeback result source
    localparam logic [1:0] resultAlu = 2'b00;
    localparam logic [1:0] resultMem = 2'b01;
    localparam logic [1:0] resultPc4 = 2'b10;
    localparam logic [1:0] resultImm = 2'b11;

    // ALU operand source, forwarding mux select
    localparam logic [1:0] fwdReg = 2'd0;
    localparam logic [1:0] fwdWb  = 2'd1;
    localparam logic [1:0] fwdMem = 2'd2;

    // Execute stage controls, 7 bits
    typedef struct packed {
        logic [2:0] aluControl;
        logic       aluSrc;
        logic       branch;
        logic       jump;
        // 1 for bne, inverts zero flag
        logic       branchType;
    } exCtrlT;

    // Memory stage controls, 3 bits
    typedef struct packed {
        logic       memWrite;
        logic [1:0] resultSrc;
    } memCtrlT;

    // Writeback stage controls with destination, 8 bits
    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;
        regAddrT    rd;
    } wbCtrlT;

    // Everything the decoder produces for one instruction
    typedef struct packed {
        exCtrlT     ex;
        memCtrlT    mem;
        logic       regWrite;
        logic [2:0] immSrc;
        regAddrT    rs1;
        regAddrT    rs2;
        regAddrT    rd;
    } decodedT;

    // Register addresses carried with an instruction, 15 bits
    typedef struct packed {
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
    } stageAddrT;

endpackage

// File: verilog/rv32Pkg.sv
/*
 * RV32I encodings for the pipeline control path.
 * Opcodes, funct3 values, ALU control, ALU op classes
 * and immediate select codes shared by the decoder.
 */
package rv32Pkg;

    // Register index
    typedef logic [4:0] regAddrT;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam logic [6:0] opStore    = 7'b0100011;
    localparam logic [6:0] opRtype    = 7'b0110011;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] opItypeAlu = 7'b0010011;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opLui      = 7'b0110111;

    // ALU funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // ALU control seen by the execute stage
    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluSub = 3'b001;
    localparam logic [2:0] aluAnd = 3'b010;
    localparam logic [2:0] aluOr  = 3'b011;
    localparam logic [2:0] aluSlt = 3'b101;

    // ALU op class from the main decoder
    localparam logic [1:0] aluOpAdd   = 2'b00;
    localparam logic [1:0] aluOpSub   = 2'b01;
    localparam logic [1:0] aluOpFunct = 2'b10;

    // Immediate formats for the extender
    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immJ = 3'b011;
    localparam logic [2:0] immU = 3'b100;

endpackage
